// ==== files.f ====
+incdir+sim
source/pwr_pkg.sv
source/pwr_regs.sv
source/pwr_delay_counter.sv
source/pwr_timed_sequencer.sv
source/pwr_cpu_domain.sv
source/pwr_level_domain.sv
source/pwr_manager_top.sv
sim/pwr_tb.sv

// ==== sim/pwr_tb_checks.svh ====
/*
  Power manager testbench helpers
  Register bus access, typed compares and bounded wait loops
*/
`ifndef PWR_TB_CHECKS_SVH
`define PWR_TB_CHECKS_SVH

  // ------------------------------------------------------------------
  // register bus
  // ------------------------------------------------------------------
  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    pwr_pkg::reg_req_t req;
    req.valid = 1'b1;
    req.write = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    @(posedge clk_i);
    reg_req <= req;
    // write lands on this edge
    @(posedge clk_i);
    reg_req <= '0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output pwr_pkg::reg_rsp_t rsp);
    pwr_pkg::reg_req_t req;
    req       = '0;
    req.valid = 1'b1;
    req.addr  = addr;
    @(posedge clk_i);
    reg_req <= req;
    // combinational read data is taken mid cycle
    @(negedge clk_i);
    rsp = reg_rsp;
    @(posedge clk_i);
    reg_req <= '0;
  endtask

  // ------------------------------------------------------------------
  // typed compares
  // ------------------------------------------------------------------
  task automatic check_ctrl(input string name, input pwr_pkg::pwr_ctrl_t got,
                            input pwr_pkg::pwr_ctrl_t want);
    if (got !== want) begin
      ctrl_errs++;
      $display("ERR %s: got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_rsp(input string name, input pwr_pkg::reg_rsp_t got,
                           input pwr_pkg::reg_rsp_t want);
    if (got !== want) begin
      rsp_errs++;
      $display("ERR %s: rdata %h error %h, expected rdata %h error %h",
               name, got.rdata, got.error, want.rdata, want.error);
    end
  endtask

  task automatic check_delay(input string what, input int cyc, input int dly,
                             input int slack);
    if (cyc < 0) begin
      seq_errs++;
      $display("%s did not happen within %0d cycles", what, WAIT_MAX);
    end else if (cyc < dly || cyc > dly + slack) begin
      seq_errs++;
      $display("%s took %0d cycles, allowed %0d to %0d", what, cyc, dly, dly + slack);
    end
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] data,
                             input logic err);
    pwr_pkg::reg_rsp_t got;
    pwr_pkg::reg_rsp_t want;
    want.rdata = data;
    want.error = err;
    bus_read(addr, got);
    check_rsp($sformatf("reg_rsp_o @%02h", addr), got, want);
  endtask

  // ------------------------------------------------------------------
  // bounded waits
  // ------------------------------------------------------------------
  // polls the ACK word until the synchronizers have caught up
  task automatic wait_ack_reg(input logic [31:0] data);
    pwr_pkg::reg_rsp_t got;
    pwr_pkg::reg_rsp_t want;
    int                i;
    want.rdata = data;
    want.error = 1'b0;
    got        = '0;
    i          = 0;
    while (got !== want && i < WAIT_MAX) begin
      bus_read(pwr_pkg::ADDR_ACK, got);
      i++;
    end
    check_rsp("reg_rsp_o ack", got, want);
  endtask

  // cycle count at which each cpu field first reaches its target
  task automatic watch_cpu(input pwr_pkg::pwr_ctrl_t target, output int sw_cyc,
                           output int iso_cyc, output int rst_cyc);
    int   i;
    logic done;
    sw_cyc  = -1;
    iso_cyc = -1;
    rst_cyc = -1;
    i       = 0;
    done    = 1'b0;
    while (!done && i < WAIT_MAX) begin
      @(negedge clk_i);
      i++;
      if (sw_cyc < 0 && cpu_ctrl.switch_n === target.switch_n) begin
        sw_cyc = i;
      end
      if (iso_cyc < 0 && cpu_ctrl.iso_n === target.iso_n) begin
        iso_cyc = i;
      end
      if (rst_cyc < 0 && cpu_ctrl.rst_n === target.rst_n) begin
        rst_cyc = i;
      end
      done = (cpu_ctrl === target);
    end
  endtask

  // cpu controls must not move during the window
  task automatic hold_cpu(input pwr_pkg::pwr_ctrl_t want, input int cycles);
    int   i;
    logic moved;
    i     = 0;
    moved = 1'b0;
    while (!moved && i < cycles) begin
      @(negedge clk_i);
      i++;
      moved = (cpu_ctrl !== want);
    end
    check_ctrl("cpu_ctrl_o", cpu_ctrl, want);
  endtask

`endif

// ==== sim/pwr_tb.sv ====
/*
  Power manager testbench
  Drives bus, acks, sleep and interrupts and checks every domain's controls
*/
`timescale 1ns/1ps

module pwr_tb;

  localparam int NUM_BANKS  = 2;
  localparam int CNT_W      = 32;
  localparam int SETTLE_MAX = 8;
  localparam int WAIT_MAX   = 40;

  logic                               clk_i;
  logic                               reset_i;
  pwr_pkg::reg_req_t                  reg_req;
  pwr_pkg::reg_rsp_t                  reg_rsp;
  logic                               core_sleep;
  logic [31:0]                        intr;
  logic                               cpu_ack;
  logic                               periph_ack;
  logic [NUM_BANKS-1:0]               ram_ack;
  pwr_pkg::pwr_ctrl_t                 cpu_ctrl;
  pwr_pkg::pwr_ctrl_t                 periph_ctrl;
  pwr_pkg::pwr_ctrl_t [NUM_BANKS-1:0] ram_ctrl;

  // configuration written so far and the controls it should give
  pwr_pkg::pwr_level_cfg_t                 periph_cfg;
  pwr_pkg::pwr_level_cfg_t [NUM_BANKS-1:0] ram_cfg;
  pwr_pkg::pwr_ctrl_t                      exp_cpu;
  pwr_pkg::pwr_ctrl_t                      exp_periph;
  pwr_pkg::pwr_ctrl_t [NUM_BANKS-1:0]      exp_ram;

  integer seed;
  int     ctrl_errs;
  int     rsp_errs;
  int     seq_errs;
  logic   cmp_busy;
  int     cmp_cycles;

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  pwr_manager_top #(.NUM_BANKS(NUM_BANKS), .CNT_W(CNT_W)) dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .reg_req_i     (reg_req),
    .reg_rsp_o     (reg_rsp),
    .core_sleep_i  (core_sleep),
    .intr_i        (intr),
    .cpu_ack_i     (cpu_ack),
    .periph_ack_i  (periph_ack),
    .ram_ack_i     (ram_ack),
    .cpu_ctrl_o    (cpu_ctrl),
    .periph_ctrl_o (periph_ctrl),
    .ram_ctrl_o    (ram_ctrl)
  );

  `include "pwr_tb_checks.svh"

  // ------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------
  // bus word to level configuration fields
  function automatic pwr_pkg::pwr_level_cfg_t level_cfg(input logic [31:0] w);
    pwr_pkg::pwr_level_cfg_t cfg;
    cfg.switch_off = w[0];
    cfg.isolate    = w[1];
    cfg.reset      = w[2];
    cfg.wait_ack   = w[3];
    return cfg;
  endfunction

  // settled controls of a level domain given its last settled state
  function automatic pwr_pkg::pwr_ctrl_t pwr_expect(input pwr_pkg::pwr_level_cfg_t cfg,
      input logic ack, input bit has_reset, input pwr_pkg::pwr_ctrl_t prev);
    pwr_pkg::pwr_ctrl_t res;
    logic               permit;
    permit       = !cfg.wait_ack || ack;
    res          = prev;
    res.switch_n = !cfg.switch_off;
    if (cfg.isolate) begin
      res.iso_n = 1'b0;
    end else if (permit && !cfg.switch_off) begin
      res.iso_n = 1'b1;
    end
    if (!has_reset) begin
      res.rst_n = 1'b1;
    end else if (cfg.reset) begin
      res.rst_n = 1'b0;
    end else if (permit) begin
      res.rst_n = 1'b1;
    end
    return res;
  endfunction

  // expected monitor word with 3 bits per domain
  function automatic logic [31:0] monitor_word();
    logic [31:0] w;
    w      = '0;
    w[2:0] = {exp_cpu.rst_n, exp_cpu.iso_n, exp_cpu.switch_n};
    w[5:3] = {exp_periph.rst_n, exp_periph.iso_n, exp_periph.switch_n};
    for (int b = 0; b < NUM_BANKS; b++) begin
      w[3*(b+2) +: 3] = {exp_ram[b].rst_n, exp_ram[b].iso_n, exp_ram[b].switch_n};
    end
    return w;
  endfunction

  // level domains are compared once they settle or the settle time runs out
  always @(negedge clk_i) begin
    if (cmp_busy) begin
      if ((periph_ctrl === exp_periph && ram_ctrl === exp_ram) ||
          cmp_cycles >= SETTLE_MAX) begin
        check_ctrl("periph_ctrl_o", periph_ctrl, exp_periph);
        for (int b = 0; b < NUM_BANKS; b++) begin
          check_ctrl($sformatf("ram_ctrl_o[%0d]", b), ram_ctrl[b], exp_ram[b]);
        end
        cmp_busy = 1'b0;
      end else begin
        cmp_cycles++;
      end
    end
  end

  task automatic level_compare();
    int i;
    cmp_cycles = 0;
    cmp_busy   = 1'b1;
    i          = 0;
    while (cmp_busy && i < WAIT_MAX) begin
      @(posedge clk_i);
      i++;
    end
    if (cmp_busy) begin
      seq_errs++;
      cmp_busy = 1'b0;
      $display("level domain compare did not finish");
    end
  endtask

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------
  initial begin
    int          off_d [3];
    int          on_d [3];
    int          c_sw;
    int          c_iso;
    int          c_rst;
    int          widx;
    logic [31:0] mask;
    logic [31:0] other;
    logic [31:0] pat;

    seed       = 18;
    ctrl_errs  = 0;
    rsp_errs   = 0;
    seq_errs   = 0;
    cmp_busy   = 1'b0;
    cmp_cycles = 0;
    reset_i    = 1'b1;
    reg_req    = '0;
    core_sleep = 1'b0;
    intr       = '0;
    cpu_ack    = 1'b0;
    periph_ack = 1'b0;
    ram_ack    = '0;
    periph_cfg = '0;
    ram_cfg    = '0;
    exp_cpu    = '1;
    exp_periph = '1;
    exp_ram    = '1;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;

    // idle after reset, zero registers, error on unmapped words
    @(negedge clk_i);
    check_ctrl("cpu_ctrl_o", cpu_ctrl, exp_cpu);
    level_compare();
    for (int a = 0; a <= 11; a++) begin
      read_expect(a, (a == pwr_pkg::ADDR_MONITOR) ? monitor_word() : 32'h0, 1'b0);
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      read_expect(pwr_pkg::ADDR_RAM_BASE + b, 32'h0, 1'b0);
    end
    read_expect(8'h0C, 32'h0, 1'b1);
    read_expect(8'h7F, 32'h0, 1'b1);

    // cpu sleep entry with random delays
    for (int k = 0; k < 3; k++) begin
      off_d[k] = $unsigned($random(seed)) % 21;
      on_d[k]  = $unsigned($random(seed)) % 21;
    end
    bus_write(pwr_pkg::ADDR_CPU_SW_OFF, off_d[0]);
    bus_write(pwr_pkg::ADDR_CPU_SW_ON, on_d[0]);
    bus_write(pwr_pkg::ADDR_CPU_ISO_OFF, off_d[1]);
    bus_write(pwr_pkg::ADDR_CPU_ISO_ON, on_d[1]);
    bus_write(pwr_pkg::ADDR_CPU_RST_OFF, off_d[2]);
    bus_write(pwr_pkg::ADDR_CPU_RST_ON, on_d[2]);
    bus_write(pwr_pkg::ADDR_CTRL, 32'h1);
    @(posedge clk_i);
    core_sleep <= 1'b1;
    watch_cpu(3'b000, c_sw, c_iso, c_rst);
    check_delay("cpu switch off", c_sw, off_d[0], 4);
    check_delay("cpu isolation", c_iso, off_d[1], 4);
    check_delay("cpu reset assert", c_rst, off_d[2], 4);
    exp_cpu = 3'b000;
    check_ctrl("cpu_ctrl_o", cpu_ctrl, exp_cpu);
    @(posedge clk_i);
    core_sleep <= 1'b0;

    // an interrupt outside the wake mask must not wake the cpu
    widx  = $unsigned($random(seed)) % 32;
    mask  = 32'h1 << widx;
    other = $random(seed) & ~mask;
    if (other == 32'h0) begin
      other = ~mask;
    end
    bus_write(pwr_pkg::ADDR_WAKE_EN, mask);
    bus_write(pwr_pkg::ADDR_CTRL, 32'h3);
    @(posedge clk_i);
    intr <= other;
    hold_cpu(exp_cpu, WAIT_MAX);
    @(posedge clk_i);
    intr <= mask;
    watch_cpu(3'b100, c_sw, c_iso, c_rst);
    check_delay("cpu switch on", c_sw, on_d[0], 4);
    // isolation and reset stay active until the ack arrives
    hold_cpu(3'b100, WAIT_MAX);
    @(posedge clk_i);
    cpu_ack <= 1'b1;
    watch_cpu(3'b111, c_sw, c_iso, c_rst);
    check_delay("cpu isolation release", c_iso, on_d[1], 6);
    check_delay("cpu reset release", c_rst, on_d[2], 6);
    exp_cpu = 3'b111;
    check_ctrl("cpu_ctrl_o", cpu_ctrl, exp_cpu);
    @(posedge clk_i);
    intr <= '0;

    // peripheral and RAM level control with random acks
    for (int it = 0; it < 16; it++) begin
      pat = $random(seed);
      @(posedge clk_i);
      cpu_ack    <= pat[0];
      periph_ack <= pat[1];
      ram_ack    <= pat[2 +: NUM_BANKS];
      wait_ack_reg(pat[NUM_BANKS+1:0]);
      exp_periph = pwr_expect(periph_cfg, pat[1], 1'b1, exp_periph);
      for (int b = 0; b < NUM_BANKS; b++) begin
        exp_ram[b] = pwr_expect(ram_cfg[b], pat[2+b], 1'b0, exp_ram[b]);
      end
      level_compare();
      other      = $random(seed);
      periph_cfg = level_cfg(other);
      bus_write(pwr_pkg::ADDR_PERIPH, other);
      read_expect(pwr_pkg::ADDR_PERIPH, {28'h0, other[3:0]}, 1'b0);
      exp_periph = pwr_expect(periph_cfg, pat[1], 1'b1, exp_periph);
      for (int b = 0; b < NUM_BANKS; b++) begin
        other      = $random(seed);
        ram_cfg[b] = level_cfg(other);
        bus_write(pwr_pkg::ADDR_RAM_BASE + b, other);
        read_expect(pwr_pkg::ADDR_RAM_BASE + b, other & 32'hB, 1'b0);
        exp_ram[b] = pwr_expect(ram_cfg[b], pat[2+b], 1'b0, exp_ram[b]);
      end
      level_compare();
      read_expect(pwr_pkg::ADDR_MONITOR, monitor_word(), 1'b0);
    end

    // sampled interrupts lag intr_i by one cycle
    for (int it = 0; it < 4; it++) begin
      pat = $random(seed);
      @(posedge clk_i);
      intr <= pat;
      read_expect(pwr_pkg::ADDR_INTR_STATE, pat, 1'b0);
    end
    read_expect(pwr_pkg::ADDR_MONITOR, monitor_word(), 1'b0);

    $display("errors: ctrl %0d, rsp %0d, sequence %0d", ctrl_errs, rsp_errs, seq_errs);
    if (ctrl_errs + rsp_errs + seq_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== source/pwr_cpu_domain.sv ====
/*
  CPU power domain
  Timed switch, isolation and reset sequencing with wake and ack handling
*/
`timescale 1ns/1ps

module pwr_cpu_domain #(
  parameter int CNT_W = 32
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  pwr_pkg::pwr_cpu_cfg_t          cfg_i,
  input  logic [pwr_pkg::REG_DATA_W-1:0] intr_state_i,
  input  logic                           core_sleep_i,
  input  logic                           ack_i,
  output pwr_pkg::pwr_ctrl_t             ctrl_o,
  output logic                           ack_sync_o
);

  logic ack_meta_q;
  logic ack_sync_q;
  logic off_trig;
  logic wake_trig;
  logic on_permit;

  // two-flop ack synchronizer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_meta_q <= 1'b0;
      ack_sync_q <= 1'b0;
    end else begin
      ack_meta_q <= ack_i;
      ack_sync_q <= ack_meta_q;
    end
  end

  assign off_trig  = cfg_i.core_gate_en & core_sleep_i;
  // any pending interrupt that is enabled for wake
  assign wake_trig = |(cfg_i.wake_mask & intr_state_i);
  assign on_permit = ~cfg_i.wait_ack | ack_sync_q;

  // ------------------------------------------------------------------
  // sequencers
  // ------------------------------------------------------------------
  pwr_timed_sequencer #(.CNT_W(CNT_W)) switch_seq_u (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .off_i       (off_trig),
    .on_i        (wake_trig),
    .on_permit_i (1'b1),
    .delay_i     (cfg_i.switch_dly),
    .active_n_o  (ctrl_o.switch_n)
  );

  pwr_timed_sequencer #(.CNT_W(CNT_W)) iso_seq_u (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .off_i       (off_trig),
    .on_i        (wake_trig),
    .on_permit_i (on_permit),
    .delay_i     (cfg_i.iso_dly),
    .active_n_o  (ctrl_o.iso_n)
  );

  pwr_timed_sequencer #(.CNT_W(CNT_W)) rst_seq_u (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .off_i       (off_trig),
    .on_i        (wake_trig),
    .on_permit_i (on_permit),
    .delay_i     (cfg_i.rst_dly),
    .active_n_o  (ctrl_o.rst_n)
  );

  assign ack_sync_o = ack_sync_q;

endmodule

// ==== source/pwr_delay_counter.sv ====
/*
  Delay counter, loaded on start and counting down to zero
*/
`timescale 1ns/1ps

module pwr_delay_counter #(
  parameter int CNT_W = 32
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             start_i,
  input  logic [CNT_W-1:0] load_i,
  output logic             done_o
);

  logic [CNT_W-1:0] count_q;
  logic             running_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      running_q <= 1'b0;
    end else if (start_i) begin
      running_q <= 1'b1;
    end else if (done_o) begin
      running_q <= 1'b0;
    end
  end

  // load on start, then step down to zero
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      count_q <= load_i;
    end else if (running_q && count_q != '0) begin
      count_q <= count_q - 1'b1;
    end
  end

  // one cycle pulse once zero is reached
  assign done_o = running_q && (count_q == '0);

endmodule

// ==== source/pwr_level_domain.sv ====
/*
  Level-controlled power domain (peripheral or RAM bank)
  Registered controls, release held until the synchronized ack when asked
*/
`timescale 1ns/1ps

module pwr_level_domain #(
  parameter bit HAS_RESET = 1'b1
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  pwr_pkg::pwr_level_cfg_t cfg_i,
  input  logic                    ack_i,
  output pwr_pkg::pwr_ctrl_t      ctrl_o,
  output logic                    ack_sync_o
);

  logic ack_meta_q;
  logic ack_sync_q;
  logic permit;
  logic switch_n_q;
  logic iso_n_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_meta_q <= 1'b0;
      ack_sync_q <= 1'b0;
    end else begin
      ack_meta_q <= ack_i;
      ack_sync_q <= ack_meta_q;
    end
  end

  assign permit = ~cfg_i.wait_ack | ack_sync_q;

  // isolation is only lifted once the switch has been on for a cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      switch_n_q <= pwr_pkg::SWITCH_IDLE;
      iso_n_q    <= pwr_pkg::ISO_IDLE;
    end else begin
      switch_n_q <= ~cfg_i.switch_off;
      if (cfg_i.isolate) begin
        iso_n_q <= 1'b0;
      end else if (permit && switch_n_q && !cfg_i.switch_off) begin
        iso_n_q <= 1'b1;
      end
    end
  end

  if (HAS_RESET) begin : g_rst
    logic rst_n_q;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        rst_n_q <= pwr_pkg::RST_IDLE;
      end else if (cfg_i.reset) begin
        rst_n_q <= 1'b0;
      end else if (permit) begin
        rst_n_q <= 1'b1;
      end
    end

    assign ctrl_o.rst_n = rst_n_q;
  end else begin : g_no_rst
    assign ctrl_o.rst_n = pwr_pkg::RST_IDLE;
  end

  assign ctrl_o.switch_n = switch_n_q;
  assign ctrl_o.iso_n    = iso_n_q;
  assign ack_sync_o      = ack_sync_q;

  iso_after_switch_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ctrl_o.iso_n) |-> ctrl_o.switch_n);

endmodule

// ==== source/pwr_manager_top.sv ====
/*
  Power manager top level
  Register file, CPU domain, peripheral domain and RAM bank domains
*/
`timescale 1ns/1ps

module pwr_manager_top #(
  parameter int NUM_BANKS = 2,
  parameter int CNT_W     = 32
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  pwr_pkg::reg_req_t                  reg_req_i,
  output pwr_pkg::reg_rsp_t                  reg_rsp_o,
  input  logic                               core_sleep_i,
  input  logic [pwr_pkg::REG_DATA_W-1:0]     intr_i,
  input  logic                               cpu_ack_i,
  input  logic                               periph_ack_i,
  input  logic [NUM_BANKS-1:0]               ram_ack_i,
  output pwr_pkg::pwr_ctrl_t                 cpu_ctrl_o,
  output pwr_pkg::pwr_ctrl_t                 periph_ctrl_o,
  output pwr_pkg::pwr_ctrl_t [NUM_BANKS-1:0] ram_ctrl_o
);

  pwr_pkg::pwr_cpu_cfg_t                   cpu_cfg;
  pwr_pkg::pwr_level_cfg_t                 periph_cfg;
  pwr_pkg::pwr_level_cfg_t [NUM_BANKS-1:0] ram_cfg;
  logic [pwr_pkg::REG_DATA_W-1:0]          intr_state;
  logic                                    cpu_ack_sync;
  logic                                    periph_ack_sync;
  logic [NUM_BANKS-1:0]                    ram_ack_sync;

  pwr_regs #(.NUM_BANKS(NUM_BANKS)) regs_u (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .reg_req_i       (reg_req_i),
    .reg_rsp_o       (reg_rsp_o),
    .intr_i          (intr_i),
    .core_status_i   (cpu_ctrl_o),
    .periph_status_i (periph_ctrl_o),
    .ram_status_i    (ram_ctrl_o),
    .ack_sync_i      ({ram_ack_sync, periph_ack_sync, cpu_ack_sync}),
    .cpu_cfg_o       (cpu_cfg),
    .intr_state_o    (intr_state),
    .periph_cfg_o    (periph_cfg),
    .ram_cfg_o       (ram_cfg)
  );

  pwr_cpu_domain #(.CNT_W(CNT_W)) cpu_u (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cfg_i        (cpu_cfg),
    .intr_state_i (intr_state),
    .core_sleep_i (core_sleep_i),
    .ack_i        (cpu_ack_i),
    .ctrl_o       (cpu_ctrl_o),
    .ack_sync_o   (cpu_ack_sync)
  );

  pwr_level_domain #(.HAS_RESET(1'b1)) periph_u (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cfg_i      (periph_cfg),
    .ack_i      (periph_ack_i),
    .ctrl_o     (periph_ctrl_o),
    .ack_sync_o (periph_ack_sync)
  );

  // RAM banks keep rst_n released
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_ram
    pwr_level_domain #(.HAS_RESET(1'b0)) ram_u (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .cfg_i      (ram_cfg[b]),
      .ack_i      (ram_ack_i[b]),
      .ctrl_o     (ram_ctrl_o[b]),
      .ack_sync_o (ram_ack_sync[b])
    );
  end

endmodule

// ==== source/pwr_pkg.sv ====
/*
  Power manager shared definitions
  Register map, register bus structs and per-domain control structs
*/
package pwr_pkg;

  localparam int REG_ADDR_W = 8;
  localparam int REG_DATA_W = 32;
  localparam int CNT_W_MAX  = 32;

  // word addresses
  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL        = 8'h00;
  localparam logic [REG_ADDR_W-1:0] ADDR_WAKE_EN     = 8'h01;
  localparam logic [REG_ADDR_W-1:0] ADDR_INTR_STATE  = 8'h02;
  localparam logic [REG_ADDR_W-1:0] ADDR_CPU_SW_OFF  = 8'h03;
  localparam logic [REG_ADDR_W-1:0] ADDR_CPU_SW_ON   = 8'h04;
  localparam logic [REG_ADDR_W-1:0] ADDR_CPU_ISO_OFF = 8'h05;
  localparam logic [REG_ADDR_W-1:0] ADDR_CPU_ISO_ON  = 8'h06;
  localparam logic [REG_ADDR_W-1:0] ADDR_CPU_RST_OFF = 8'h07;
  localparam logic [REG_ADDR_W-1:0] ADDR_CPU_RST_ON  = 8'h08;
  localparam logic [REG_ADDR_W-1:0] ADDR_PERIPH      = 8'h09;
  localparam logic [REG_ADDR_W-1:0] ADDR_ACK         = 8'h0A;
  localparam logic [REG_ADDR_W-1:0] ADDR_MONITOR     = 8'h0B;
  // one word per RAM bank from here on
  localparam logic [REG_ADDR_W-1:0] ADDR_RAM_BASE    = 8'h10;

  // inactive levels of the active-low controls
  localparam logic SWITCH_IDLE = 1'b1;
  localparam logic ISO_IDLE    = 1'b1;
  localparam logic RST_IDLE    = 1'b1;

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [REG_DATA_W-1:0] rdata;
    logic                  error;
  } reg_rsp_t;

  typedef struct packed {
    logic switch_n;
    logic iso_n;
    logic rst_n;
  } pwr_ctrl_t;

  typedef struct packed {
    logic [CNT_W_MAX-1:0] off_val;
    logic [CNT_W_MAX-1:0] on_val;
  } pwr_delay_t;

  typedef struct packed {
    pwr_delay_t            switch_dly;
    pwr_delay_t            iso_dly;
    pwr_delay_t            rst_dly;
    logic                  core_gate_en;
    logic                  wait_ack;
    logic [REG_DATA_W-1:0] wake_mask;
  } pwr_cpu_cfg_t;

  typedef struct packed {
    logic switch_off;
    logic isolate;
    logic reset;
    logic wait_ack;
  } pwr_level_cfg_t;

endpackage

// ==== source/pwr_regs.sv ====
/*
  Power manager register file
  Bus decode, configuration registers, interrupt sampling and status readback
*/
`timescale 1ns/1ps

module pwr_regs #(
  parameter int NUM_BANKS = 2
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  pwr_pkg::reg_req_t                      reg_req_i,
  output pwr_pkg::reg_rsp_t                      reg_rsp_o,
  input  logic [pwr_pkg::REG_DATA_W-1:0]         intr_i,
  input  pwr_pkg::pwr_ctrl_t                     core_status_i,
  input  pwr_pkg::pwr_ctrl_t                     periph_status_i,
  input  pwr_pkg::pwr_ctrl_t [NUM_BANKS-1:0]     ram_status_i,
  input  logic [NUM_BANKS+1:0]                   ack_sync_i,
  output pwr_pkg::pwr_cpu_cfg_t                  cpu_cfg_o,
  output logic [pwr_pkg::REG_DATA_W-1:0]         intr_state_o,
  output pwr_pkg::pwr_level_cfg_t                periph_cfg_o,
  output pwr_pkg::pwr_level_cfg_t [NUM_BANKS-1:0] ram_cfg_o
);

  localparam int AW = pwr_pkg::REG_ADDR_W;
  localparam int DW = pwr_pkg::REG_DATA_W;

  pwr_pkg::pwr_cpu_cfg_t                   cpu_cfg_q;
  pwr_pkg::pwr_level_cfg_t                 periph_q;
  pwr_pkg::pwr_level_cfg_t [NUM_BANKS-1:0] ram_q;
  logic [DW-1:0]                           intr_state_q;
  logic [NUM_BANKS-1:0]                    ram_hit;
  logic [3*(NUM_BANKS+2)-1:0]              monitor;
  logic [DW-1:0]                           rdata;
  logic                                    hit;
  logic                                    wr_en;
  logic                                    ro_write;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      ram_hit[b] = (reg_req_i.addr == pwr_pkg::ADDR_RAM_BASE + AW'(b));
    end
  end

  // ------------------------------------------------------------------
  // writable registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cpu_cfg_q <= '0;
      periph_q  <= '0;
      ram_q     <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr)
        pwr_pkg::ADDR_CTRL: begin
          cpu_cfg_q.core_gate_en <= reg_req_i.wdata[0];
          cpu_cfg_q.wait_ack     <= reg_req_i.wdata[1];
        end
        pwr_pkg::ADDR_WAKE_EN:     cpu_cfg_q.wake_mask          <= reg_req_i.wdata;
        pwr_pkg::ADDR_CPU_SW_OFF:  cpu_cfg_q.switch_dly.off_val <= reg_req_i.wdata;
        pwr_pkg::ADDR_CPU_SW_ON:   cpu_cfg_q.switch_dly.on_val  <= reg_req_i.wdata;
        pwr_pkg::ADDR_CPU_ISO_OFF: cpu_cfg_q.iso_dly.off_val    <= reg_req_i.wdata;
        pwr_pkg::ADDR_CPU_ISO_ON:  cpu_cfg_q.iso_dly.on_val     <= reg_req_i.wdata;
        pwr_pkg::ADDR_CPU_RST_OFF: cpu_cfg_q.rst_dly.off_val    <= reg_req_i.wdata;
        pwr_pkg::ADDR_CPU_RST_ON:  cpu_cfg_q.rst_dly.on_val     <= reg_req_i.wdata;
        pwr_pkg::ADDR_PERIPH: begin
          periph_q.switch_off <= reg_req_i.wdata[0];
          periph_q.isolate    <= reg_req_i.wdata[1];
          periph_q.reset      <= reg_req_i.wdata[2];
          periph_q.wait_ack   <= reg_req_i.wdata[3];
        end
        default: ;
      endcase
      // bit2 is not stored since banks have no domain reset
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (ram_hit[b]) begin
          ram_q[b].switch_off <= reg_req_i.wdata[0];
          ram_q[b].isolate    <= reg_req_i.wdata[1];
          ram_q[b].wait_ack   <= reg_req_i.wdata[3];
        end
      end
    end
  end

  // interrupts sampled every cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr_state_q <= '0;
    end else begin
      intr_state_q <= intr_i;
    end
  end

  // ------------------------------------------------------------------
  // read mux
  // ------------------------------------------------------------------
  // 3 bits per domain with switch_n lowest
  always_comb begin
    monitor[2:0] = {core_status_i.rst_n, core_status_i.iso_n, core_status_i.switch_n};
    monitor[5:3] = {periph_status_i.rst_n, periph_status_i.iso_n, periph_status_i.switch_n};
    for (int b = 0; b < NUM_BANKS; b++) begin
      monitor[3*(b+2) +: 3] = {ram_status_i[b].rst_n, ram_status_i[b].iso_n,
                               ram_status_i[b].switch_n};
    end
  end

  always_comb begin
    rdata = '0;
    hit   = 1'b1;
    case (reg_req_i.addr)
      pwr_pkg::ADDR_CTRL:        rdata = DW'({cpu_cfg_q.wait_ack, cpu_cfg_q.core_gate_en});
      pwr_pkg::ADDR_WAKE_EN:     rdata = cpu_cfg_q.wake_mask;
      pwr_pkg::ADDR_INTR_STATE:  rdata = intr_state_q;
      pwr_pkg::ADDR_CPU_SW_OFF:  rdata = cpu_cfg_q.switch_dly.off_val;
      pwr_pkg::ADDR_CPU_SW_ON:   rdata = cpu_cfg_q.switch_dly.on_val;
      pwr_pkg::ADDR_CPU_ISO_OFF: rdata = cpu_cfg_q.iso_dly.off_val;
      pwr_pkg::ADDR_CPU_ISO_ON:  rdata = cpu_cfg_q.iso_dly.on_val;
      pwr_pkg::ADDR_CPU_RST_OFF: rdata = cpu_cfg_q.rst_dly.off_val;
      pwr_pkg::ADDR_CPU_RST_ON:  rdata = cpu_cfg_q.rst_dly.on_val;
      pwr_pkg::ADDR_PERIPH:      rdata = DW'({periph_q.wait_ack, periph_q.reset,
                                              periph_q.isolate, periph_q.switch_off});
      pwr_pkg::ADDR_ACK:         rdata = DW'(ack_sync_i);
      pwr_pkg::ADDR_MONITOR:     rdata = DW'(monitor);
      default:                   hit   = 1'b0;
    endcase
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (ram_hit[b]) begin
        rdata = DW'({ram_q[b].wait_ack, 1'b0, ram_q[b].isolate, ram_q[b].switch_off});
        hit   = 1'b1;
      end
    end
  end

  assign reg_rsp_o.rdata = rdata;
  assign reg_rsp_o.error = reg_req_i.valid & ~hit;

  assign cpu_cfg_o    = cpu_cfg_q;
  assign intr_state_o = intr_state_q;
  assign periph_cfg_o = periph_q;
  assign ram_cfg_o    = ram_q;

  // status words are read only
  assign ro_write = wr_en && (reg_req_i.addr == pwr_pkg::ADDR_INTR_STATE ||
                              reg_req_i.addr == pwr_pkg::ADDR_ACK ||
                              reg_req_i.addr == pwr_pkg::ADDR_MONITOR);

  ro_write_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ro_write |=> $stable({cpu_cfg_q, periph_q, ram_q}));

endmodule

// ==== source/pwr_timed_sequencer.sv ====
/*
  Timed off/on sequencer for one active-low control signal
*/
`timescale 1ns/1ps

module pwr_timed_sequencer #(
  parameter int CNT_W = 32
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                off_i,
  input  logic                on_i,
  input  logic                on_permit_i,
  input  pwr_pkg::pwr_delay_t delay_i,
  output logic                active_n_o
);

  typedef enum logic [1:0] {
    ST_ON,
    ST_COUNT_OFF,
    ST_OFF,
    ST_COUNT_ON
  } seq_state_e;

  seq_state_e state_q, state_d;
  logic       active_n_q, active_n_d;
  logic       start_off, start_on;
  logic       off_done, on_done;

  always_comb begin
    state_d    = state_q;
    active_n_d = active_n_q;
    start_off  = 1'b0;
    start_on   = 1'b0;
    case (state_q)
      ST_ON: begin
        if (off_i) begin
          start_off = 1'b1;
          state_d   = ST_COUNT_OFF;
        end
      end
      ST_COUNT_OFF: begin
        if (off_done) begin
          state_d    = ST_OFF;
          active_n_d = 1'b0;
        end
      end
      ST_OFF: begin
        // wake waits for permission, e.g. the power switch ack
        if (on_i && on_permit_i) begin
          start_on = 1'b1;
          state_d  = ST_COUNT_ON;
        end
      end
      ST_COUNT_ON: begin
        if (on_done) begin
          state_d    = ST_ON;
          active_n_d = 1'b1;
        end
      end
      default: state_d = ST_ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= ST_ON;
      active_n_q <= 1'b1;
    end else begin
      state_q    <= state_d;
      active_n_q <= active_n_d;
    end
  end

  pwr_delay_counter #(.CNT_W(CNT_W)) off_cnt_u (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (start_off),
    .load_i  (delay_i.off_val[CNT_W-1:0]),
    .done_o  (off_done)
  );

  pwr_delay_counter #(.CNT_W(CNT_W)) on_cnt_u (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (start_on),
    .load_i  (delay_i.on_val[CNT_W-1:0]),
    .done_o  (on_done)
  );

  assign active_n_o = active_n_q;

  change_after_expiry_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $changed(active_n_o) |-> $past(off_done || on_done));

endmodule
